// File: source/isa_pkg.sv
// Instruction set package with field types, opcodes, shift, ALU and branch condition codes
package isa_pkg;

   localparam int WORD_W = 16;
   localparam int REG_IDX_W = 3;
   localparam int PC_W = 8;
   localparam int ADDR_W = 9;
   localparam int NUM_REGS = 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [PC_W-1:0] pc_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // Major opcode in bits 15 to 13
   typedef enum logic [2:0] {
      OPC_B    = 3'b001,
      OPC_LDR  = 3'b011,
      OPC_STR  = 3'b100,
      OPC_ALU  = 3'b101,
      OPC_MOV  = 3'b110,
      OPC_HALT = 3'b111
   } opcode_t;

   // Sub-operation in bits 12 to 11
   typedef logic [1:0] op_t;

   localparam op_t OP_ADD = 2'b00;
   localparam op_t OP_CMP = 2'b01;
   localparam op_t OP_AND = 2'b10;
   localparam op_t OP_MVN = 2'b11;
   localparam op_t OP_MOV_REG = 2'b00;
   localparam op_t OP_MOV_IMM = 2'b10;

   // Applied to the second operand only
   typedef enum logic [1:0] {
      SH_NONE = 2'b00,
      SH_LSL  = 2'b01,
      SH_LSR  = 2'b10,
      SH_ASR  = 2'b11
   } shift_t;

   // Carried in the Rn field of a branch
   typedef enum logic [2:0] {
      COND_AL = 3'b000,
      COND_EQ = 3'b001,
      COND_NE = 3'b010,
      COND_LT = 3'b011,
      COND_LE = 3'b100
   } cond_t;

   typedef logic [2:0] status_t;

   localparam int STATUS_Z = 2;
   localparam int STATUS_N = 1;
   localparam int STATUS_V = 0;

endpackage

// File: source/ctrl_pkg.sv
// Controller package with state encoding, memory commands and write-back source select
package ctrl_pkg;

   localparam int STATE_W = 4;

   typedef enum logic [STATE_W-1:0] {
      st_reset      = 4'd0,
      st_fetch      = 4'd1,
      st_load_ir    = 4'd2,
      st_decode     = 4'd3,
      st_read       = 4'd4,
      st_execute    = 4'd5,
      st_write_back = 4'd6,
      st_mov_imm    = 4'd7,
      st_addr_calc  = 4'd8,
      st_addr_load  = 4'd9,
      st_mem_read   = 4'd10,
      st_store      = 4'd11,
      st_branch     = 4'd12,
      st_halt       = 4'd13
   } state_t;

   typedef enum logic [1:0] {
      MEM_WRITE = 2'b00,
      MEM_READ  = 2'b01
   } mem_cmd_t;

   typedef enum logic [1:0] {
      VSEL_ALU = 2'b00,
      VSEL_IMM = 2'b01,
      VSEL_MEM = 2'b10
   } vsel_t;

endpackage

// File: source/register_file.sv
// Register file of eight 16-bit registers with two read ports and one write port
`timescale 1ns/10ps

module register_file (
   input  logic              clk,
   input  logic              reg_write,
   input  isa_pkg::reg_idx_t write_num,
   input  isa_pkg::word_t    write_value,
   input  isa_pkg::reg_idx_t read_num_a,
   input  isa_pkg::reg_idx_t read_num_b,
   output isa_pkg::word_t    value_a,
   output isa_pkg::word_t    value_b
);

   isa_pkg::word_t regs [isa_pkg::NUM_REGS];

   always_ff @(posedge clk) begin
      if (reg_write) begin
         regs[write_num] <= write_value;
      end
   end

   // Reads are combinational
   assign value_a = regs[read_num_a];
   assign value_b = regs[read_num_b];

   a_write_num_known: assert property (@(posedge clk)
      reg_write |-> !$isunknown(write_num));

endmodule

// File: source/datapath.sv
// Datapath with operand registers, shifter, ALU, status flags and result register
`timescale 1ns/10ps

module datapath (
   input  logic              clk,
   input  logic              reset,
   input  logic              load_a,
   input  logic              load_b,
   input  logic              load_c,
   input  logic              asel,
   input  logic              bsel,
   input  logic              load_status,
   input  logic              reg_write,
   input  ctrl_pkg::vsel_t   vsel,
   input  isa_pkg::reg_idx_t read_num_a,
   input  isa_pkg::reg_idx_t read_num_b,
   input  isa_pkg::reg_idx_t write_num,
   input  isa_pkg::shift_t   shift,
   input  isa_pkg::op_t      op,
   input  isa_pkg::word_t    sximm5,
   input  isa_pkg::word_t    sximm8,
   input  isa_pkg::word_t    read_data,
   output isa_pkg::word_t    result,
   output isa_pkg::status_t  status
);

   isa_pkg::word_t value_a;
   isa_pkg::word_t value_b;
   isa_pkg::word_t write_value;
   isa_pkg::word_t reg_a;
   isa_pkg::word_t reg_b;
   isa_pkg::word_t b_shifted;
   isa_pkg::word_t ain;
   isa_pkg::word_t bin;
   isa_pkg::word_t alu_out;
   logic overflow;

   register_file rf0 (
      .clk(clk), .reg_write(reg_write), .write_num(write_num), .write_value(write_value),
      .read_num_a(read_num_a), .read_num_b(read_num_b), .value_a(value_a), .value_b(value_b)
   );

   always_comb begin
      case (vsel)
         ctrl_pkg::VSEL_IMM: write_value = sximm8;
         ctrl_pkg::VSEL_MEM: write_value = read_data;
         default:            write_value = result;
      endcase
   end

   always_ff @(posedge clk) begin
      if (load_a) begin
         reg_a <= value_a;
      end
      if (load_b) begin
         reg_b <= value_b;
      end
      if (load_c) begin
         result <= alu_out;
      end
   end

   always_comb begin
      case (shift)
         isa_pkg::SH_LSL: b_shifted = reg_b << 1;
         isa_pkg::SH_LSR: b_shifted = reg_b >> 1;
         isa_pkg::SH_ASR: b_shifted = $signed(reg_b) >>> 1;
         default:         b_shifted = reg_b;
      endcase
   end

   assign ain = asel ? '0 : reg_a;
   assign bin = bsel ? sximm5 : b_shifted;

   always_comb begin
      case (op)
         isa_pkg::OP_ADD: alu_out = ain + bin;
         isa_pkg::OP_CMP: alu_out = ain - bin;
         isa_pkg::OP_AND: alu_out = ain & bin;
         default:         alu_out = ~bin;
      endcase
   end

   // Signed overflow of the subtraction
   assign overflow = (ain[isa_pkg::WORD_W-1] ^ bin[isa_pkg::WORD_W-1])
                   & (alu_out[isa_pkg::WORD_W-1] ^ ain[isa_pkg::WORD_W-1]);

   always_ff @(posedge clk) begin
      if (reset) begin
         status <= '0;
      end else if (load_status) begin
         status[isa_pkg::STATUS_Z] <= (alu_out == '0);
         status[isa_pkg::STATUS_N] <= alu_out[isa_pkg::WORD_W-1];
         status[isa_pkg::STATUS_V] <= overflow;
      end
   end

endmodule

// File: source/instruction_unit.sv
// Instruction register with field decode, immediate sign extension and branch decision
`timescale 1ns/10ps

module instruction_unit (
   input  logic              clk,
   input  logic              load_ir,
   input  isa_pkg::word_t    read_data,
   input  isa_pkg::status_t  status,
   output isa_pkg::opcode_t  opcode,
   output isa_pkg::op_t      op,
   output isa_pkg::reg_idx_t rn,
   output isa_pkg::reg_idx_t rd,
   output isa_pkg::reg_idx_t rm,
   output isa_pkg::shift_t   shift,
   output isa_pkg::word_t    sximm5,
   output isa_pkg::word_t    sximm8,
   output isa_pkg::pc_t      branch_offset,
   output logic              branch_taken
);

   isa_pkg::word_t ir;
   logic shift_used;
   logic less_than;

   always_ff @(posedge clk) begin
      if (load_ir) begin
         ir <= read_data;
      end
   end

   assign opcode = isa_pkg::opcode_t'(ir[15:13]);
   assign op = ir[12:11];
   assign rn = ir[10:8];
   assign rd = ir[7:5];
   assign rm = ir[2:0];

   // Bits 4 to 3 are offset bits in loads and stores
   assign shift_used = (opcode == isa_pkg::OPC_ALU) || (opcode == isa_pkg::OPC_MOV);
   assign shift = shift_used ? isa_pkg::shift_t'(ir[4:3]) : isa_pkg::SH_NONE;

   assign sximm5 = {{11{ir[4]}}, ir[4:0]};
   assign sximm8 = {{8{ir[7]}}, ir[7:0]};
   assign branch_offset = ir[7:0];

   assign less_than = status[isa_pkg::STATUS_N] ^ status[isa_pkg::STATUS_V];

   always_comb begin
      case (isa_pkg::cond_t'(rn))
         isa_pkg::COND_AL: branch_taken = 1'b1;
         isa_pkg::COND_EQ: branch_taken = status[isa_pkg::STATUS_Z];
         isa_pkg::COND_NE: branch_taken = !status[isa_pkg::STATUS_Z];
         isa_pkg::COND_LT: branch_taken = less_than;
         isa_pkg::COND_LE: branch_taken = less_than || status[isa_pkg::STATUS_Z];
         default:          branch_taken = 1'b0;
      endcase
   end

endmodule

// File: source/address_unit.sv
// Program counter, data address register and memory address select
`timescale 1ns/10ps

module address_unit (
   input  logic           clk,
   input  logic           load_pc,
   input  logic           reset_pc,
   input  logic           take_branch,
   input  logic           branch_taken,
   input  isa_pkg::pc_t   branch_offset,
   input  logic           load_addr,
   input  logic           addr_sel,
   input  isa_pkg::addr_t data_addr_in,
   output isa_pkg::addr_t mem_addr
);

   isa_pkg::pc_t pc;
   isa_pkg::pc_t next_pc;
   isa_pkg::addr_t data_addr;

   // Branch offset applies to the already incremented PC
   always_comb begin
      if (reset_pc) begin
         next_pc = '0;
      end else if (take_branch) begin
         next_pc = branch_taken ? pc + branch_offset : pc;
      end else begin
         next_pc = pc + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (load_pc) begin
         pc <= next_pc;
      end
      if (load_addr) begin
         data_addr <= data_addr_in;
      end
   end

   assign mem_addr = addr_sel ? {1'b0, pc} : data_addr;

endmodule

// File: source/control_fsm.sv
// Multicycle controller that sequences fetch, decode and execute of each instruction
`timescale 1ns/10ps

module control_fsm (
   input  logic               clk,
   input  logic               reset,
   input  isa_pkg::opcode_t   opcode,
   input  isa_pkg::op_t       op,
   input  isa_pkg::reg_idx_t  rn,
   input  isa_pkg::reg_idx_t  rd,
   input  isa_pkg::reg_idx_t  rm,
   output logic               load_ir,
   output logic               load_pc,
   output logic               reset_pc,
   output logic               take_branch,
   output logic               load_addr,
   output logic               addr_sel,
   output logic               load_a,
   output logic               load_b,
   output logic               load_c,
   output logic               asel,
   output logic               bsel,
   output logic               load_status,
   output logic               reg_write,
   output ctrl_pkg::vsel_t    vsel,
   output isa_pkg::reg_idx_t  read_num_a,
   output isa_pkg::reg_idx_t  read_num_b,
   output isa_pkg::reg_idx_t  write_num,
   output ctrl_pkg::mem_cmd_t mem_cmd,
   output logic               halt
);

   ctrl_pkg::state_t state;
   ctrl_pkg::state_t next_state;
   logic is_mem_op;
   logic is_cmp;

   assign is_mem_op = (opcode == isa_pkg::OPC_LDR) || (opcode == isa_pkg::OPC_STR);
   assign is_cmp = (opcode == isa_pkg::OPC_ALU) && (op == isa_pkg::OP_CMP);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ctrl_pkg::st_reset;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = ctrl_pkg::st_halt;
      case (state)
         ctrl_pkg::st_reset:   next_state = ctrl_pkg::st_fetch;
         ctrl_pkg::st_fetch:   next_state = ctrl_pkg::st_load_ir;
         ctrl_pkg::st_load_ir: next_state = ctrl_pkg::st_decode;
         ctrl_pkg::st_decode: begin
            case (opcode)
               isa_pkg::OPC_MOV: begin
                  if (op == isa_pkg::OP_MOV_IMM) begin
                     next_state = ctrl_pkg::st_mov_imm;
                  end else if (op == isa_pkg::OP_MOV_REG) begin
                     next_state = ctrl_pkg::st_read;
                  end
               end
               isa_pkg::OPC_ALU: next_state = ctrl_pkg::st_read;
               isa_pkg::OPC_LDR: next_state = ctrl_pkg::st_read;
               isa_pkg::OPC_STR: next_state = ctrl_pkg::st_read;
               isa_pkg::OPC_B:   next_state = ctrl_pkg::st_branch;
               default:          next_state = ctrl_pkg::st_halt;
            endcase
         end
         ctrl_pkg::st_read:
            next_state = is_mem_op ? ctrl_pkg::st_addr_calc : ctrl_pkg::st_execute;
         // CMP only updates the flags
         ctrl_pkg::st_execute:
            next_state = is_cmp ? ctrl_pkg::st_fetch : ctrl_pkg::st_write_back;
         ctrl_pkg::st_write_back: next_state = ctrl_pkg::st_fetch;
         ctrl_pkg::st_mov_imm:    next_state = ctrl_pkg::st_fetch;
         ctrl_pkg::st_addr_calc:  next_state = ctrl_pkg::st_addr_load;
         ctrl_pkg::st_addr_load:
            next_state = (opcode == isa_pkg::OPC_STR) ? ctrl_pkg::st_store
                                                      : ctrl_pkg::st_mem_read;
         // Load data shows up one cycle after the address goes out
         ctrl_pkg::st_mem_read:   next_state = ctrl_pkg::st_write_back;
         ctrl_pkg::st_store:      next_state = ctrl_pkg::st_fetch;
         ctrl_pkg::st_branch:     next_state = ctrl_pkg::st_fetch;
         default:                 next_state = ctrl_pkg::st_halt;
      endcase
   end

   always_comb begin
      load_ir = 1'b0;
      load_pc = 1'b0;
      reset_pc = 1'b0;
      take_branch = 1'b0;
      load_addr = 1'b0;
      addr_sel = 1'b1;
      load_a = 1'b0;
      load_b = 1'b0;
      load_c = 1'b0;
      asel = 1'b0;
      bsel = 1'b0;
      load_status = 1'b0;
      reg_write = 1'b0;
      vsel = ctrl_pkg::VSEL_ALU;
      read_num_a = rn;
      read_num_b = rm;
      write_num = rd;
      mem_cmd = ctrl_pkg::MEM_READ;
      halt = 1'b0;
      case (state)
         ctrl_pkg::st_reset: begin
            load_pc = 1'b1;
            reset_pc = 1'b1;
         end
         ctrl_pkg::st_load_ir: begin
            load_ir = 1'b1;
            load_pc = 1'b1;
         end
         ctrl_pkg::st_read: begin
            load_a = 1'b1;
            load_b = 1'b1;
            // A store carries its data register in Rd
            if (opcode == isa_pkg::OPC_STR) begin
               read_num_b = rd;
            end
         end
         ctrl_pkg::st_execute: begin
            load_c = 1'b1;
            asel = (opcode == isa_pkg::OPC_MOV);
            load_status = is_cmp;
         end
         ctrl_pkg::st_write_back: begin
            reg_write = 1'b1;
            vsel = (opcode == isa_pkg::OPC_LDR) ? ctrl_pkg::VSEL_MEM : ctrl_pkg::VSEL_ALU;
         end
         ctrl_pkg::st_mov_imm: begin
            reg_write = 1'b1;
            vsel = ctrl_pkg::VSEL_IMM;
            write_num = rn;
         end
         ctrl_pkg::st_addr_calc: begin
            load_c = 1'b1;
            bsel = 1'b1;
         end
         // Address moves out of C while store data moves into it
         ctrl_pkg::st_addr_load: begin
            load_addr = 1'b1;
            load_c = 1'b1;
            asel = 1'b1;
         end
         ctrl_pkg::st_mem_read: addr_sel = 1'b0;
         ctrl_pkg::st_store: begin
            addr_sel = 1'b0;
            mem_cmd = ctrl_pkg::MEM_WRITE;
         end
         ctrl_pkg::st_branch: begin
            load_pc = 1'b1;
            take_branch = 1'b1;
         end
         ctrl_pkg::st_halt: halt = 1'b1;
         default: ;
      endcase
   end

   a_no_write_clash: assert property (@(posedge clk) disable iff (reset)
      !(reg_write && (mem_cmd == ctrl_pkg::MEM_WRITE)));

   a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halt |=> halt);

endmodule

// File: source/cpu.sv
// Processor top level joining controller, instruction unit, datapath and address unit
`timescale 1ns/10ps

module cpu (
   input  logic               clk,
   input  logic               reset,
   input  isa_pkg::word_t     read_data,
   output ctrl_pkg::mem_cmd_t mem_cmd,
   output isa_pkg::addr_t     mem_addr,
   output isa_pkg::word_t     write_data,
   output logic               halt
);

   logic load_ir;
   logic load_pc;
   logic reset_pc;
   logic take_branch;
   logic load_addr;
   logic addr_sel;
   logic load_a;
   logic load_b;
   logic load_c;
   logic asel;
   logic bsel;
   logic load_status;
   logic reg_write;
   ctrl_pkg::vsel_t vsel;
   isa_pkg::reg_idx_t read_num_a;
   isa_pkg::reg_idx_t read_num_b;
   isa_pkg::reg_idx_t write_num;

   // Decoded instruction fields
   isa_pkg::opcode_t opcode;
   isa_pkg::op_t op;
   isa_pkg::reg_idx_t rn;
   isa_pkg::reg_idx_t rd;
   isa_pkg::reg_idx_t rm;
   isa_pkg::shift_t shift;
   isa_pkg::word_t sximm5;
   isa_pkg::word_t sximm8;
   isa_pkg::pc_t branch_offset;
   logic branch_taken;
   isa_pkg::status_t status;

   control_fsm fsm0 (
      .clk(clk), .reset(reset), .opcode(opcode), .op(op), .rn(rn), .rd(rd), .rm(rm),
      .load_ir(load_ir), .load_pc(load_pc), .reset_pc(reset_pc), .take_branch(take_branch),
      .load_addr(load_addr), .addr_sel(addr_sel), .load_a(load_a), .load_b(load_b),
      .load_c(load_c), .asel(asel), .bsel(bsel), .load_status(load_status),
      .reg_write(reg_write), .vsel(vsel), .read_num_a(read_num_a), .read_num_b(read_num_b),
      .write_num(write_num), .mem_cmd(mem_cmd), .halt(halt)
   );

   instruction_unit iu0 (
      .clk(clk), .load_ir(load_ir), .read_data(read_data), .status(status),
      .opcode(opcode), .op(op), .rn(rn), .rd(rd), .rm(rm), .shift(shift),
      .sximm5(sximm5), .sximm8(sximm8), .branch_offset(branch_offset),
      .branch_taken(branch_taken)
   );

   datapath dp0 (
      .clk(clk), .reset(reset), .load_a(load_a), .load_b(load_b), .load_c(load_c),
      .asel(asel), .bsel(bsel), .load_status(load_status), .reg_write(reg_write),
      .vsel(vsel), .read_num_a(read_num_a), .read_num_b(read_num_b), .write_num(write_num),
      .shift(shift), .op(op), .sximm5(sximm5), .sximm8(sximm8), .read_data(read_data),
      .result(write_data), .status(status)
   );

   // Low bits of C serve as the data address
   address_unit au0 (
      .clk(clk), .load_pc(load_pc), .reset_pc(reset_pc), .take_branch(take_branch),
      .branch_taken(branch_taken), .branch_offset(branch_offset), .load_addr(load_addr),
      .addr_sel(addr_sel), .data_addr_in(write_data[isa_pkg::ADDR_W-1:0]),
      .mem_addr(mem_addr)
   );

endmodule

// File: bench/clock_gen.sv
// Clock source for the testbench with a 4 ns period
`timescale 1ns/10ps

module clock_gen (
   output logic clk
);

   localparam int HALF_PERIOD_NS = 2;

   initial begin
      clk = 1'b0;
      forever begin
         #HALF_PERIOD_NS clk = ~clk;
      end
   end

endmodule

// File: bench/cpu_checker.sv
// Instruction-level reference model that checks every store and the final halt
`timescale 1ns/10ps

module cpu_checker (
   input  logic               clk,
   input  logic               reset,
   input  ctrl_pkg::mem_cmd_t mem_cmd,
   input  isa_pkg::addr_t     mem_addr,
   input  isa_pkg::word_t     write_data,
   input  logic               halt,
   output int                 error_count,
   output int                 store_count
);

   localparam int MEM_WORDS = 512;
   localparam int MAX_STEPS = 1000;

   isa_pkg::word_t img [MEM_WORDS];
   isa_pkg::addr_t exp_addr [$];
   isa_pkg::word_t exp_data [$];
   logic halt_seen;
   logic prev_reset;

   initial begin
      error_count = 0;
      store_count = 0;
      halt_seen = 1'b0;
      prev_reset = 1'b1;
   end

   function automatic isa_pkg::word_t shift_operand(isa_pkg::word_t value, logic [1:0] code);
      case (code)
         2'b01:   return {value[14:0], 1'b0};
         2'b10:   return {1'b0, value[15:1]};
         2'b11:   return {value[15], value[15:1]};
         default: return value;
      endcase
   endfunction

   task automatic set_word(input isa_pkg::addr_t addr, input isa_pkg::word_t value);
      img[addr] = value;
   endtask

   // Runs the program image once and queues the stores it makes
   task automatic run_model();
      isa_pkg::word_t regs [isa_pkg::NUM_REGS];
      isa_pkg::word_t ir;
      isa_pkg::word_t a;
      isa_pkg::word_t b;
      isa_pkg::word_t diff;
      isa_pkg::addr_t addr;
      isa_pkg::pc_t pc;
      int sdiff;
      logic z;
      logic n;
      logic v;
      logic lt;
      logic taken;
      logic done;
      int steps;
      exp_addr.delete();
      exp_data.delete();
      halt_seen = 1'b0;
      foreach (regs[i]) begin
         regs[i] = '0;
      end
      pc = '0;
      z = 1'b0;
      n = 1'b0;
      v = 1'b0;
      done = 1'b0;
      steps = 0;
      while (!done) begin
         ir = img[{1'b0, pc}];
         pc = pc + 8'd1;
         a = regs[ir[10:8]];
         b = shift_operand(regs[ir[2:0]], ir[4:3]);
         addr = isa_pkg::addr_t'(a + {{11{ir[4]}}, ir[4:0]});
         case (isa_pkg::opcode_t'(ir[15:13]))
            isa_pkg::OPC_MOV: begin
               if (ir[12:11] == isa_pkg::OP_MOV_IMM) begin
                  regs[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
               end else if (ir[12:11] == isa_pkg::OP_MOV_REG) begin
                  regs[ir[7:5]] = b;
               end else begin
                  done = 1'b1;
               end
            end
            isa_pkg::OPC_ALU: begin
               case (ir[12:11])
                  2'b00: regs[ir[7:5]] = a + b;
                  2'b01: begin
                     diff = a - b;
                     sdiff = int'($signed(a)) - int'($signed(b));
                     z = (diff == 16'd0);
                     n = diff[15];
                     // Overflow when the true signed difference leaves the 16-bit range
                     v = (sdiff > 32767) || (sdiff < -32768);
                  end
                  2'b10:   regs[ir[7:5]] = a & b;
                  default: regs[ir[7:5]] = ~b;
               endcase
            end
            isa_pkg::OPC_LDR: regs[ir[7:5]] = img[addr];
            isa_pkg::OPC_STR: begin
               img[addr] = regs[ir[7:5]];
               exp_addr.push_back(addr);
               exp_data.push_back(regs[ir[7:5]]);
            end
            isa_pkg::OPC_B: begin
               lt = n ^ v;
               case (ir[10:8])
                  3'd0:    taken = 1'b1;
                  3'd1:    taken = z;
                  3'd2:    taken = !z;
                  3'd3:    taken = lt;
                  3'd4:    taken = lt || z;
                  default: taken = 1'b0;
               endcase
               if (taken) begin
                  pc = pc + ir[7:0];
               end
            end
            default: done = 1'b1;
         endcase
         steps++;
         if (steps > MAX_STEPS && !done) begin
            $display("ERROR at %0t ns: model ran past %0d instructions", $time, MAX_STEPS);
            error_count++;
            done = 1'b1;
         end
      end
   endtask

   task automatic end_program();
      if (halt !== 1'b1) begin
         $display("ERROR at %0t ns: halt expected 1, got %b", $time, halt);
         error_count++;
      end
   endtask

   task automatic check_store();
      if (halt_seen) begin
         $display("ERROR at %0t ns: store to %h after halt", $time, mem_addr);
         error_count++;
      end else if (exp_addr.size() == 0) begin
         $display("ERROR at %0t ns: unexpected store of %h to %h", $time, write_data, mem_addr);
         error_count++;
      end else begin
         if (mem_addr !== exp_addr[0]) begin
            $display("ERROR at %0t ns: mem_addr expected %h, got %h",
                     $time, exp_addr[0], mem_addr);
            error_count++;
         end
         if (write_data !== exp_data[0]) begin
            $display("ERROR at %0t ns: write_data expected %h, got %h",
                     $time, exp_data[0], write_data);
            error_count++;
         end
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
         store_count++;
      end
   endtask

   // A write seen at the falling edge lands at the next rising edge
   always @(negedge clk) begin
      if (reset) begin
         prev_reset = 1'b1;
      end else begin
         if (prev_reset && (mem_addr !== '0 || mem_cmd !== ctrl_pkg::MEM_READ
                            || halt !== 1'b0)) begin
            $display("ERROR at %0t ns: first cycle after reset is not a read of address 0",
                     $time);
            error_count++;
         end
         prev_reset = 1'b0;
         if (mem_cmd == ctrl_pkg::MEM_WRITE) begin
            check_store();
         end
         if (halt && !halt_seen) begin
            halt_seen = 1'b1;
            if (exp_addr.size() != 0) begin
               $display("ERROR at %0t ns: halt came with %0d stores still expected",
                        $time, exp_addr.size());
               error_count++;
            end
         end
      end
   end

endmodule

// File: bench/cpu_tb.sv
// Testbench top that builds random programs, serves as memory and drives reset
`timescale 1ns/10ps

module cpu_tb;

   localparam int NUM_PROGRAMS = 40;
   localparam int RANDOM_INSTRS = 30;
   localparam int RESET_CYCLES = 16;
   localparam int TIMEOUT_CYCLES = NUM_PROGRAMS * 40 * 12;
   localparam int MEM_WORDS = 512;
   localparam int STORES_START = isa_pkg::NUM_REGS + RANDOM_INSTRS;
   // r7 holds 0xff80, so loads and stores land near word 384
   localparam int BASE_REG = 7;

   logic clk;
   logic reset;
   isa_pkg::word_t read_data;
   ctrl_pkg::mem_cmd_t mem_cmd;
   isa_pkg::addr_t mem_addr;
   isa_pkg::word_t write_data;
   logic halt;
   int error_count;
   int store_count;
   int cycle_count;
   int programs_done;
   int seed;
   isa_pkg::word_t mem [MEM_WORDS];
   isa_pkg::word_t rd_value;

   clock_gen clk0 (.clk(clk));

   cpu dut0 (
      .clk(clk), .reset(reset), .read_data(read_data), .mem_cmd(mem_cmd),
      .mem_addr(mem_addr), .write_data(write_data), .halt(halt)
   );

   cpu_checker chk0 (
      .clk(clk), .reset(reset), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
      .write_data(write_data), .halt(halt), .error_count(error_count),
      .store_count(store_count)
   );

   // Read data lags one cycle and holds the word from before a same-edge write
   always @(posedge clk) begin
      rd_value = mem[mem_addr];
      if (mem_cmd == ctrl_pkg::MEM_WRITE) begin
         mem[mem_addr] = write_data;
      end
      #1 read_data = rd_value;
   end

   task automatic report_counts();
      $display("Programs run: %0d, stores checked: %0d, errors: %0d",
               programs_done, store_count, error_count);
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: halt not reached within %0d cycles", TIMEOUT_CYCLES);
         report_counts();
         $display("Something failed");
         $finish;
      end
   end

   task automatic rand_below(input int limit, output int value);
      value = int'($unsigned($random(seed)) % limit);
   endtask

   task automatic build_program();
      int i;
      int pc;
      int kind;
      int rn;
      int rd;
      int rm;
      int sh;
      int imm;
      int cond;
      isa_pkg::word_t w;
      for (i = 0; i < MEM_WORDS; i++) begin
         mem[isa_pkg::addr_t'(i)] = 16'(i * 40503) ^ 16'h3c5a;
      end
      for (i = 0; i < isa_pkg::NUM_REGS; i++) begin
         rand_below(256, imm);
         if (i == BASE_REG) begin
            imm = 128;
         end
         mem[isa_pkg::addr_t'(i)] = {isa_pkg::OPC_MOV, isa_pkg::OP_MOV_IMM, 3'(i), 8'(imm)};
      end
      pc = isa_pkg::NUM_REGS;
      while (pc < STORES_START) begin
         rand_below(9, kind);
         rand_below(7, rd);
         rand_below(8, rn);
         rand_below(8, rm);
         rand_below(4, sh);
         rand_below(256, imm);
         rand_below(5, cond);
         case (kind)
            0: w = {isa_pkg::OPC_MOV, isa_pkg::OP_MOV_IMM, 3'(rd), 8'(imm)};
            1: w = {isa_pkg::OPC_MOV, isa_pkg::OP_MOV_REG, 3'(rn), 3'(rd), 2'(sh), 3'(rm)};
            2, 3, 4: w = {isa_pkg::OPC_ALU, 2'((kind == 2) ? 0 : kind - 1), 3'(rn), 3'(rd),
                          2'(sh), 3'(rm)};
            5: w = {isa_pkg::OPC_ALU, isa_pkg::OP_CMP, 3'(rn), 3'(rd), 2'(sh), 3'(rm)};
            6: begin
               // Forward offsets that stop at the closing stores
               rand_below(((STORES_START - pc - 1) < 6 ? STORES_START - pc - 1 : 6) + 1, imm);
               w = {isa_pkg::OPC_B, 2'b00, 3'(cond), 8'(imm)};
            end
            7: w = {isa_pkg::OPC_LDR, isa_pkg::OP_ADD, 3'(BASE_REG), 3'(rd), 5'(imm)};
            default: w = {isa_pkg::OPC_STR, isa_pkg::OP_ADD, 3'(BASE_REG), 3'(rn), 5'(imm)};
         endcase
         mem[isa_pkg::addr_t'(pc)] = w;
         pc++;
      end
      for (i = 0; i < isa_pkg::NUM_REGS; i++) begin
         mem[isa_pkg::addr_t'(pc)] = {isa_pkg::OPC_STR, isa_pkg::OP_ADD, 3'(BASE_REG), 3'(i),
                                      5'(i)};
         pc++;
      end
      mem[isa_pkg::addr_t'(pc)] = {isa_pkg::OPC_HALT, 13'd0};
      for (i = 0; i < MEM_WORDS; i++) begin
         chk0.set_word(isa_pkg::addr_t'(i), mem[isa_pkg::addr_t'(i)]);
      end
   endtask

   initial begin
      int prog;
      reset = 1'b1;
      read_data = '0;
      cycle_count = 0;
      programs_done = 0;
      seed = 32'hbd2a_5a7d;
      for (prog = 0; prog < NUM_PROGRAMS; prog++) begin
         @(posedge clk);
         #1;
         build_program();
         chk0.run_model();
         reset = 1'b1;
         repeat (RESET_CYCLES) @(posedge clk);
         #1 reset = 1'b0;
         while (!halt) begin
            @(posedge clk);
            #1;
         end
         // A few more cycles to catch a store after halt
         repeat (4) @(posedge clk);
         #1;
         chk0.end_program();
         programs_done++;
      end
      report_counts();
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: all.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/register_file.sv
source/datapath.sv
source/instruction_unit.sv
source/address_unit.sv
source/control_fsm.sv
source/cpu.sv
bench/clock_gen.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log
	! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log
